// ==== design/exec_pkg.sv ====
package exec_pkg;

    localparam int data_width = 32;  // operand and result width.
    localparam int imm_width  = 16;  // half-word immediate.

    typedef logic [data_width-1:0] word_t;
    typedef logic [imm_width-1:0]  half_t;
    typedef logic [6:0]            opcode_t;

    // datapath work.
    localparam opcode_t op_add      = 7'd0;
    localparam opcode_t op_sub      = 7'd1;
    localparam opcode_t op_shl      = 7'd2;   // ones-filling.
    localparam opcode_t op_shr      = 7'd3;   // ones-filling.
    localparam opcode_t op_mov      = 7'd4;
    localparam opcode_t op_load     = 7'd5;
    localparam opcode_t op_load_alt = 7'd6;
    localparam opcode_t op_mov_alt  = 7'd7;

    // condition flags.
    localparam opcode_t op_eq       = 7'd8;
    localparam opcode_t op_lt       = 7'd9;   // unsigned.
    localparam opcode_t op_gt       = 7'd10;  // unsigned.
    localparam opcode_t op_nf1      = 7'd11;
    localparam opcode_t op_and_f    = 7'd12;
    localparam opcode_t op_nf2      = 7'd13;

    // branches toward reg8.
    localparam opcode_t op_jump     = 7'd14;
    localparam opcode_t op_jump_f1  = 7'd15;

endpackage

// ==== design/opcode_decode.sv ====
`timescale 1ns/1ps

module opcode_decode (
    input  exec_pkg::opcode_t instr,
    output logic              sel_add,
    output logic              sel_sub,
    output logic              sel_shl,
    output logic              sel_shr,
    output logic              sel_mov,
    output logic              sel_load,
    output logic              sel_eq,
    output logic              sel_lt,
    output logic              sel_gt,
    output logic              sel_nf1,
    output logic              sel_and_f,
    output logic              sel_nf2,
    output logic              sel_jump,
    output logic              sel_jump_f1
);

    // datapath selects.
    assign sel_add  = (instr == exec_pkg::op_add);
    assign sel_sub  = (instr == exec_pkg::op_sub);
    assign sel_shl  = (instr == exec_pkg::op_shl);
    assign sel_shr  = (instr == exec_pkg::op_shr);
    assign sel_mov  = (instr == exec_pkg::op_mov) |
                      (instr == exec_pkg::op_mov_alt);  // two codes, same work.
    assign sel_load = (instr == exec_pkg::op_load) |
                      (instr == exec_pkg::op_load_alt);

    // flag selects.
    assign sel_eq    = (instr == exec_pkg::op_eq);
    assign sel_lt    = (instr == exec_pkg::op_lt);
    assign sel_gt    = (instr == exec_pkg::op_gt);
    assign sel_nf1   = (instr == exec_pkg::op_nf1);
    assign sel_and_f = (instr == exec_pkg::op_and_f);
    assign sel_nf2   = (instr == exec_pkg::op_nf2);

    // codes 16 and up fall through here with every select low.
    assign sel_jump    = (instr == exec_pkg::op_jump);
    assign sel_jump_f1 = (instr == exec_pkg::op_jump_f1);

endmodule

// ==== design/alu_datapath.sv ====
`timescale 1ns/1ps

module alu_datapath #(
    parameter int data_width = exec_pkg::data_width,
    parameter int imm_width  = exec_pkg::imm_width
) (
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    input  exec_pkg::half_t value,
    input  logic            highlow,
    input  logic            sel_add,
    input  logic            sel_sub,
    input  logic            sel_shl,
    input  logic            sel_shr,
    input  logic            sel_mov,
    input  logic            sel_load,
    output exec_pkg::word_t alu_result
);

    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    exec_pkg::word_t shl_ones;
    exec_pkg::word_t shr_ones;
    exec_pkg::word_t loaded;

    exec_pkg::word_t oc_add;
    exec_pkg::word_t oc_sub;
    exec_pkg::word_t oc_shl;
    exec_pkg::word_t oc_shr;
    exec_pkg::word_t oc_mov;
    exec_pkg::word_t oc_load;

    assign sum  = a + b;  // wraps on overflow.
    assign diff = a - b;

    // invert, shift, invert back so vacated bits become ones.
    // an amount of data_width or more shifts everything out, giving all ones.
    assign shl_ones = ~((~a) << b);
    assign shr_ones = ~((~a) >> b);

    // immediate lands in the chosen half, the other half of a is kept.
    assign loaded = highlow ? {value, a[imm_width-1:0]}
                            : {a[data_width-1:imm_width], value};

    // gate each candidate by its select.
    assign oc_add  = sum      & {data_width{sel_add}};
    assign oc_sub  = diff     & {data_width{sel_sub}};
    assign oc_shl  = shl_ones & {data_width{sel_shl}};
    assign oc_shr  = shr_ones & {data_width{sel_shr}};
    assign oc_mov  = a        & {data_width{sel_mov}};
    assign oc_load = loaded   & {data_width{sel_load}};

    // selects are one-hot, so OR-ing is a mux. none active gives zero.
    assign alu_result = (oc_add | oc_sub) | (oc_shl | oc_shr) | (oc_mov | oc_load);

endmodule

// ==== design/condition_unit.sv ====
`timescale 1ns/1ps

module condition_unit #(
    parameter int data_width = exec_pkg::data_width
) (
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    input  exec_pkg::word_t reg8,
    input  logic            f1,
    input  logic            f2,
    input  logic            sel_eq,
    input  logic            sel_lt,
    input  logic            sel_gt,
    input  logic            sel_nf1,
    input  logic            sel_and_f,
    input  logic            sel_nf2,
    input  logic            sel_jump,
    input  logic            sel_jump_f1,
    output logic            flag,
    output logic            taken,
    output exec_pkg::word_t target
);

    logic f_eq;
    logic f_lt;
    logic f_gt;
    logic f_nf1;
    logic f_and;
    logic f_nf2;

    assign f_eq  = (a == b) & sel_eq;
    assign f_lt  = (a < b)  & sel_lt;  // unsigned.
    assign f_gt  = (a > b)  & sel_gt;
    assign f_nf1 = ~f1       & sel_nf1;
    assign f_and = (f1 & f2) & sel_and_f;
    assign f_nf2 = ~f2       & sel_nf2;

    assign flag = (f_eq | f_lt) | (f_gt | f_nf1) | (f_and | f_nf2);

    // jump always, jump_f1 only on f1.
    assign taken = sel_jump | (sel_jump_f1 & f1);

    assign target = reg8 & {data_width{taken}};  // zero when not taken.

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ps

module result_stage #(
    parameter int data_width = exec_pkg::data_width
) (
    input  logic            clock,
    input  logic            rst_n,
    input  exec_pkg::word_t alu_result,
    input  exec_pkg::word_t target,
    input  logic            flag,
    input  logic            taken,
    output exec_pkg::word_t c,
    output exec_pkg::word_t next_addr,
    output logic            f3,
    output logic            addr_change
);

    // one cycle from inputs to outputs, a new op every edge.
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            c           <= {data_width{1'b0}};
            next_addr   <= {data_width{1'b0}};
            f3          <= 1'b0;
            addr_change <= 1'b0;
        end
        else
        begin
            c           <= alu_result;
            next_addr   <= target;
            f3          <= flag;
            addr_change <= taken;  // next_addr is only valid with this.
        end
    end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit #(
    parameter int data_width = exec_pkg::data_width,
    parameter int imm_width  = exec_pkg::imm_width
) (
    input  logic              clock,
    input  logic              rst_n,
    input  exec_pkg::opcode_t instr,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::word_t   reg8,
    input  exec_pkg::half_t   value,
    input  logic              highlow,
    input  logic              f1,
    input  logic              f2,
    output exec_pkg::word_t   c,
    output logic              f3,
    output logic              addr_change,
    output exec_pkg::word_t   next_addr
);

    logic sel_add;
    logic sel_sub;
    logic sel_shl;
    logic sel_shr;
    logic sel_mov;
    logic sel_load;
    logic sel_eq;
    logic sel_lt;
    logic sel_gt;
    logic sel_nf1;
    logic sel_and_f;
    logic sel_nf2;
    logic sel_jump;
    logic sel_jump_f1;

    exec_pkg::word_t alu_result;
    exec_pkg::word_t target;
    logic            flag;
    logic            taken;

    opcode_decode u_decode (
        .instr       (instr),
        .sel_add     (sel_add),
        .sel_sub     (sel_sub),
        .sel_shl     (sel_shl),
        .sel_shr     (sel_shr),
        .sel_mov     (sel_mov),
        .sel_load    (sel_load),
        .sel_eq      (sel_eq),
        .sel_lt      (sel_lt),
        .sel_gt      (sel_gt),
        .sel_nf1     (sel_nf1),
        .sel_and_f   (sel_and_f),
        .sel_nf2     (sel_nf2),
        .sel_jump    (sel_jump),
        .sel_jump_f1 (sel_jump_f1)
    );

    alu_datapath #(
        .data_width (data_width),
        .imm_width  (imm_width)
    ) u_alu (
        .a          (a),
        .b          (b),
        .value      (value),
        .highlow    (highlow),
        .sel_add    (sel_add),
        .sel_sub    (sel_sub),
        .sel_shl    (sel_shl),
        .sel_shr    (sel_shr),
        .sel_mov    (sel_mov),
        .sel_load   (sel_load),
        .alu_result (alu_result)
    );

    condition_unit #(
        .data_width (data_width)
    ) u_cond (
        .a           (a),
        .b           (b),
        .reg8        (reg8),
        .f1          (f1),
        .f2          (f2),
        .sel_eq      (sel_eq),
        .sel_lt      (sel_lt),
        .sel_gt      (sel_gt),
        .sel_nf1     (sel_nf1),
        .sel_and_f   (sel_and_f),
        .sel_nf2     (sel_nf2),
        .sel_jump    (sel_jump),
        .sel_jump_f1 (sel_jump_f1),
        .flag        (flag),
        .taken       (taken),
        .target      (target)
    );

    result_stage #(
        .data_width (data_width)
    ) u_result (
        .clock       (clock),
        .rst_n       (rst_n),
        .alu_result  (alu_result),
        .target      (target),
        .flag        (flag),
        .taken       (taken),
        .c           (c),
        .next_addr   (next_addr),
        .f3          (f3),
        .addr_change (addr_change)
    );

endmodule

// ==== tests/exec_unit_checker.sv ====
`timescale 1ns/1ps

module exec_unit_checker (
    input logic            clock,
    input logic            rst_n,
    input exec_pkg::word_t reg8,
    input exec_pkg::word_t c,
    input logic            f3,
    input logic            addr_change,
    input exec_pkg::word_t next_addr
);

    int failures = 0;  // failed assertions so far.

    // outputs cleared one edge after reset is seen.
    assert property (@(posedge clock) !rst_n |=> (c == '0 && !f3 && !addr_change &&
                                                  next_addr == '0))
    else
    begin
        $error("outputs not cleared after reset");
        failures = failures + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
                     addr_change |-> next_addr == $past(reg8))
    else
    begin
        $error("next_addr differs from reg8 of the branch op");
        failures = failures + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
                     !addr_change |-> next_addr == '0)
    else
    begin
        $error("next_addr nonzero without a taken branch");
        failures = failures + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n) !(f3 && addr_change))
    else
    begin
        $error("f3 and addr_change high together");
        failures = failures + 1;
    end

endmodule

bind exec_unit exec_unit_checker u_checker (
    .clock       (clock),
    .rst_n       (rst_n),
    .reg8        (reg8),
    .c           (c),
    .f3          (f3),
    .addr_change (addr_change),
    .next_addr   (next_addr)
);

// ==== tests/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb;

    typedef struct packed {
        exec_pkg::opcode_t instr;
        exec_pkg::word_t   a;
        exec_pkg::word_t   b;
        exec_pkg::word_t   reg8;
        exec_pkg::half_t   value;
        logic              highlow;
        logic              f1;
        logic              f2;
        exec_pkg::word_t   exp_c;
        logic              exp_f3;
        logic              exp_ac;
        exec_pkg::word_t   exp_na;
    } row_t;

    localparam int reset_cycles = 5;
    localparam int num_random   = 200;

    logic              clock;
    logic              rst_n;
    exec_pkg::opcode_t instr;
    exec_pkg::word_t   a;
    exec_pkg::word_t   b;
    exec_pkg::word_t   reg8;
    exec_pkg::half_t   value;
    logic              highlow;
    logic              f1;
    logic              f2;
    exec_pkg::word_t   c;
    logic              f3;
    logic              addr_change;
    exec_pkg::word_t   next_addr;

    row_t rows [64];
    row_t pending [$];  // expected outputs, oldest first.
    int   due [$];
    row_t head;
    row_t rnd;
    int   n_rows = 0;
    int   cycle = 0;
    int   max_cycles = 0;
    int   errors = 0;
    int   seed_val;

    exec_unit #(
        .data_width (exec_pkg::data_width),
        .imm_width  (exec_pkg::imm_width)
    ) UUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr       (instr),
        .a           (a),
        .b           (b),
        .reg8        (reg8),
        .value       (value),
        .highlow     (highlow),
        .f1          (f1),
        .f2          (f2),
        .c           (c),
        .f3          (f3),
        .addr_change (addr_change),
        .next_addr   (next_addr)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic add_row(input exec_pkg::opcode_t op, input exec_pkg::word_t ra,
                           input exec_pkg::word_t rb, input exec_pkg::word_t r8,
                           input exec_pkg::half_t val, input logic hl, input logic rf1,
                           input logic rf2, input exec_pkg::word_t ec, input logic ef3,
                           input logic eac, input exec_pkg::word_t ena);
        rows[n_rows] = {op, ra, rb, r8, val, hl, rf1, rf2, ec, ef3, eac, ena};
        n_rows = n_rows + 1;
    endtask

    // expected outputs straight from the opcode rules.
    function automatic row_t model(input row_t r);
        row_t e;
        e = r;
        e.exp_c  = '0;
        e.exp_f3 = 1'b0;
        e.exp_ac = 1'b0;
        e.exp_na = '0;
        case (r.instr)
            exec_pkg::op_add: e.exp_c = r.a + r.b;
            exec_pkg::op_sub: e.exp_c = r.a - r.b;
            exec_pkg::op_shl: e.exp_c = (r.b >= 32) ? '1 : (r.a << r.b) | ((32'd1 << r.b) - 1);
            exec_pkg::op_shr: e.exp_c = (r.b >= 32) ? '1 : (r.a >> r.b) | ~(32'hffffffff >> r.b);
            exec_pkg::op_mov, exec_pkg::op_mov_alt: e.exp_c = r.a;
            exec_pkg::op_load, exec_pkg::op_load_alt:
                e.exp_c = r.highlow ? {r.value, r.a[15:0]} : {r.a[31:16], r.value};
            exec_pkg::op_eq:    e.exp_f3 = (r.a == r.b);
            exec_pkg::op_lt:    e.exp_f3 = (r.a < r.b);
            exec_pkg::op_gt:    e.exp_f3 = (r.a > r.b);
            exec_pkg::op_nf1:   e.exp_f3 = !r.f1;
            exec_pkg::op_and_f: e.exp_f3 = r.f1 && r.f2;
            exec_pkg::op_nf2:   e.exp_f3 = !r.f2;
            exec_pkg::op_jump:
            begin
                e.exp_ac = 1'b1;
                e.exp_na = r.reg8;
            end
            exec_pkg::op_jump_f1:
            begin
                e.exp_ac = r.f1;
                e.exp_na = r.f1 ? r.reg8 : '0;
            end
            default: ;  // unused codes.
        endcase
        return e;
    endfunction

    task automatic check_word(input string name, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    // drive one op on the rising edge, expect it after the next one.
    task automatic apply_op(input row_t r, input logic rst_val);
        row_t e;
        e = r;
        if (!rst_val)
        begin
            e.exp_c  = '0;
            e.exp_f3 = 1'b0;
            e.exp_ac = 1'b0;
            e.exp_na = '0;
        end
        @(posedge clock);
        rst_n   <= rst_val;
        instr   <= r.instr;
        a       <= r.a;
        b       <= r.b;
        reg8    <= r.reg8;
        value   <= r.value;
        highlow <= r.highlow;
        f1      <= r.f1;
        f2      <= r.f2;
        pending.push_back(e);
        due.push_back(cycle + 1);
    endtask

    // outputs are settled half a cycle after the edge.
    always @(negedge clock)
    begin
        if (due.size() > 0 && due[0] == cycle)
        begin
            head = pending.pop_front();
            due.delete(0);
            check_word("c", c, head.exp_c);
            check_bit("f3", f3, head.exp_f3);
            check_bit("addr_change", addr_change, head.exp_ac);
            check_word("next_addr", next_addr, head.exp_na);
        end
        cycle = cycle + 1;
        if (max_cycles > 0 && cycle >= max_cycles)
        begin
            $display("timeout: outputs stopped being checked");
            errors = errors + 1;
            $display("errors: %0d, assertion failures: %0d", errors,
                     UUT.u_checker.failures);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        seed_val = $urandom(32'hffd9);
        rst_n = 1'b0;
        instr = '0;
        a = '0;
        b = '0;
        reg8 = '0;
        value = '0;
        highlow = 1'b0;
        f1 = 1'b0;
        f2 = 1'b0;

        add_row(exec_pkg::op_add, 'h5, 'h7, 0, 0, 0, 0, 0, 'hc, 0, 0, 0);
        add_row(exec_pkg::op_add, 'hffffffff, 'h1, 0, 0, 0, 0, 0, 'h0, 0, 0, 0);
        add_row(exec_pkg::op_add, 'h7fffffff, 'h1, 0, 0, 0, 0, 0, 'h80000000, 0, 0, 0);
        add_row(exec_pkg::op_sub, 'ha, 'h3, 0, 0, 0, 0, 0, 'h7, 0, 0, 0);
        add_row(exec_pkg::op_sub, 'h3, 'ha, 0, 0, 0, 0, 0, 'hfffffff9, 0, 0, 0);
        add_row(exec_pkg::op_shl, 'h12345678, 0, 0, 0, 0, 0, 0, 'h12345678, 0, 0, 0);
        add_row(exec_pkg::op_shl, 'h12345678, 5, 0, 0, 0, 0, 0, 'h468acf1f, 0, 0, 0);
        add_row(exec_pkg::op_shl, 'h12345678, 31, 0, 0, 0, 0, 0, 'h7fffffff, 0, 0, 0);
        add_row(exec_pkg::op_shl, 'h12345678, 40, 0, 0, 0, 0, 0, 'hffffffff, 0, 0, 0);
        add_row(exec_pkg::op_shr, 'h12345678, 0, 0, 0, 0, 0, 0, 'h12345678, 0, 0, 0);
        add_row(exec_pkg::op_shr, 'h12345678, 5, 0, 0, 0, 0, 0, 'hf891a2b3, 0, 0, 0);
        add_row(exec_pkg::op_shr, 'h12345678, 31, 0, 0, 0, 0, 0, 'hfffffffe, 0, 0, 0);
        add_row(exec_pkg::op_shr, 'h12345678, 40, 0, 0, 0, 0, 0, 'hffffffff, 0, 0, 0);
        add_row(exec_pkg::op_mov, 'hdeadbeef, 'h1, 0, 0, 0, 0, 0, 'hdeadbeef, 0, 0, 0);
        add_row(exec_pkg::op_mov_alt, 'hcafef00d, 0, 0, 0, 0, 0, 0, 'hcafef00d, 0, 0, 0);
        add_row(exec_pkg::op_load, 'h12345678, 0, 0, 'habcd, 1, 0, 0, 'habcd5678, 0, 0, 0);
        add_row(exec_pkg::op_load, 'h12345678, 0, 0, 'habcd, 0, 0, 0, 'h1234abcd, 0, 0, 0);
        add_row(exec_pkg::op_load_alt, 'hffff0000, 0, 0, 'h1111, 1, 0, 0, 'h11110000, 0, 0, 0);
        add_row(exec_pkg::op_load_alt, 'hffff0000, 0, 0, 'h1111, 0, 0, 0, 'hffff1111, 0, 0, 0);
        add_row(exec_pkg::op_eq, 'h55, 'h55, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        add_row(exec_pkg::op_eq, 'h55, 'h56, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(exec_pkg::op_lt, 'h3, 'h9, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        add_row(exec_pkg::op_lt, 'h80000000, 'h1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(exec_pkg::op_gt, 'h80000000, 'h1, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        add_row(exec_pkg::op_gt, 'h4, 'h4, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(exec_pkg::op_nf1, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 0);
        add_row(exec_pkg::op_nf1, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row(exec_pkg::op_and_f, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
        add_row(exec_pkg::op_and_f, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row(exec_pkg::op_and_f, 0, 0, 0, 0, 0, 1, 1, 0, 1, 0, 0);
        add_row(exec_pkg::op_nf2, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0);
        add_row(exec_pkg::op_nf2, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
        add_row(exec_pkg::op_jump, 'h5, 'h6, 'h1000, 0, 0, 0, 0, 0, 0, 1, 'h1000);
        add_row(exec_pkg::op_jump_f1, 0, 0, 'h2000, 0, 0, 1, 0, 0, 0, 1, 'h2000);
        add_row(exec_pkg::op_jump_f1, 0, 0, 'h3000, 0, 0, 0, 1, 0, 0, 0, 0);
        add_row(7'd16, 'hffffffff, 'h1, 'h4000, 'hffff, 1, 1, 1, 0, 0, 0, 0);
        add_row(7'd127, 'h9, 'h9, 'h5000, 'h1234, 0, 1, 1, 0, 0, 0, 0);
        max_cycles = reset_cycles + n_rows + num_random + 20;

        repeat (reset_cycles - 1) @(posedge clock);
        for (int i = 0; i < n_rows; i++)
            apply_op(rows[i], 1'b1);

        // reset in the middle of a run.
        apply_op(rows[0], 1'b1);
        apply_op(rows[0], 1'b0);
        apply_op(rows[13], 1'b0);

        for (int i = 0; i < num_random; i++)
        begin
            rnd.instr   = $urandom % 20;
            rnd.a       = $urandom;
            rnd.b       = ($urandom % 4 == 0) ? ($urandom % 48) : $urandom;
            rnd.reg8    = $urandom;
            rnd.value   = $urandom;
            rnd.highlow = $urandom % 2;
            rnd.f1      = $urandom % 2;
            rnd.f2      = $urandom % 2;
            if ($urandom % 8 == 0)
                rnd.b = rnd.a;  // hit eq now and then.
            apply_op(model(rnd), 1'b1);
        end

        while (due.size() > 0)
            @(negedge clock);
        $display("errors: %0d, assertion failures: %0d", errors,
                 UUT.u_checker.failures);
        if (errors == 0 && UUT.u_checker.failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
design/exec_pkg.sv
design/opcode_decode.sv
design/alu_datapath.sv
design/condition_unit.sv
design/result_stage.sv
design/exec_unit.sv
tests/exec_unit_checker.sv
tests/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - files:
      - design/exec_pkg.sv
      - design/opcode_decode.sv
      - design/alu_datapath.sv
      - design/condition_unit.sv
      - design/result_stage.sv
      - design/exec_unit.sv
  - target: test
    files:
      - tests/exec_unit_checker.sv
      - tests/exec_unit_tb.sv
